//--- Bender.yml
package:
  name: mvu_top

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mvu_pkg.sv
      - hw/wb_pkg.sv
      - hw/mvu_plane_mem.sv
      - hw/mvu_agu.sv
      - hw/mvu_controller.sv
      - hw/mvu_vvp_shacc.sv
      - hw/mvu_wb_regs.sv
      - hw/mvu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/mvu_tb_clock.sv
      - bench/mvu_top_tb.sv

//--- bench/mvu_tb_clock.sv
//--------------------------------------------------------------------------
// Testbench clock and reset generator
// Free-running clock, active-low reset held for a fixed number of cycles
//--------------------------------------------------------------------------
module mvu_tb_clock #(
    parameter int PERIOD     = 8,       // Clock period in time units
    parameter int RST_CYCLES = 4        // Rising edges with rst_n low
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                // Released just after the edge
    end

endmodule

//--- bench/mvu_top_tb.sv
//--------------------------------------------------------------------------
// Testbench of the bit-serial MVU
// Wishbone bus tasks, job table, golden matrix-vector model
// Reset, unsigned, signed, completion, busy-start and base address tests
//--------------------------------------------------------------------------
`include "mvu_config.svh"

module mvu_top_tb;
    import mvu_pkg::*;
    import wb_pkg::*;

    localparam logic [31:0] SEED = 32'hbab8036d;
    localparam int BUS_TMO  = 16;       // Cycles to wait for one ack
    localparam int POLL_TMO = 200;      // Status reads to wait for done
    localparam int RST_TMO  = 32;       // Cycles to wait for reset release

    // One job of the stimulus table
    typedef struct packed {
        logic [3:0] iprec;
        logic [3:0] wprec;
        logic       d_signed;
        logic       w_signed;
        logic       rnd;                // Random operands, else fixed extremes
        logic [2:0] test;               // Test that runs the row
    } job_row_t;

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        irq;

    job_row_t    rows [12];
    int          n_rows;
    logic [7:0]  xv [2][`MVU_N];              // Raw data bits per operand set
    logic [7:0]  wv [2][`MVU_N][`MVU_N];      // Raw weight bits, row then column
    int          expect_y [2][`MVU_N];
    int          checks;
    int          errors;
    int          test_errors;                 // Error count when the test began
    logic [31:0] status;
    logic [31:0] rdata;

    mvu_tb_clock #(.PERIOD(8), .RST_CYCLES(4)) i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mvu_top i_mvu_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .irq    (irq)
    );

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        errors++;
        end_run();
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t: %s got %0d expected %0d",
                     $time, what, $signed(got), $signed(exp));
            errors++;
        end
    endtask

    // Drives one classic cycle just after the edge, holds it until ack
    task automatic bus_access(input logic we, input logic [11:0] adr,
                              input logic [31:0] dat, output logic [31:0] rd);
        int n;
        @(posedge clk);
        #1;
        wb_req       = '0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = dat;
        wb_req.sel   = 4'hf;
        n = 0;
        while (!wb_rsp.ack) begin
            if (n == BUS_TMO)
                stop_on_timeout($sformatf("no ack for address 0x%03h", adr));
            @(posedge clk);
            #1;
            n++;
        end
        rd     = wb_rsp.dat_r;          // Valid together with ack
        wb_req = '0;
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input logic [11:0] adr, output logic [31:0] dat);
        bus_access(1'b0, adr, 32'h0, dat);
    endtask

    task automatic add_row(input int ip, input int wp, input logic ds, input logic ws,
                           input logic rnd, input int test);
        rows[n_rows] = {4'(ip), 4'(wp), ds, ws, rnd, 3'(test)};
        n_rows++;
    endtask

    task automatic fill_table();
        n_rows = 0;
        add_row(1, 1, 1'b0, 1'b0, 1'b1, 2);
        add_row(4, 2, 1'b0, 1'b0, 1'b1, 2);
        add_row(8, 8, 1'b0, 1'b0, 1'b1, 2);
        add_row(8, 8, 1'b0, 1'b0, 1'b0, 2);     // Largest unsigned values
        add_row(4, 4, 1'b1, 1'b0, 1'b1, 3);
        add_row(3, 5, 1'b0, 1'b1, 1'b1, 3);
        add_row(6, 7, 1'b1, 1'b1, 1'b1, 3);
        add_row(8, 8, 1'b1, 1'b1, 1'b0, 3);     // Most negative on both sides
        add_row(2, 8, 1'b1, 1'b0, 1'b0, 3);
        add_row(4, 2, 1'b1, 1'b1, 1'b1, 4);
        add_row(8, 8, 1'b0, 1'b0, 1'b1, 5);
        add_row(4, 4, 1'b1, 1'b1, 1'b1, 6);
    endtask

    function automatic int first_row(input int test);
        for (int i = 0; i < n_rows; i++)
            if (rows[i].test == 3'(test))
                return i;
        return 0;
    endfunction

    function automatic logic [7:0] prec_mask(input int prec);
        return 8'((1 << prec) - 1);
    endfunction

    // Two's complement at its precision when signed, plain binary otherwise
    function automatic int operand_value(input logic [7:0] bits, input int prec,
                                         input logic sgn);
        int v;
        v = int'(bits & prec_mask(prec));
        if (sgn && ((v >> (prec - 1)) & 1))
            v = v - (1 << prec);
        return v;
    endfunction

    task automatic make_operands(input int set, input job_row_t row);
        logic [7:0] dmsb;
        logic [7:0] wmsb;
        dmsb = 8'(1 << (row.iprec - 1));
        wmsb = 8'(1 << (row.wprec - 1));
        for (int k = 0; k < `MVU_N; k++)
            xv[set][k] = row.rnd ? 8'($urandom) & prec_mask(row.iprec) :
                         (k % 2 == 0) ? dmsb : prec_mask(row.iprec);
        for (int r = 0; r < `MVU_N; r++)
            for (int k = 0; k < `MVU_N; k++)
                wv[set][r][k] = row.rnd ? 8'($urandom) & prec_mask(row.wprec) :
                                ((r + k) % 2 == 0) ? wmsb : prec_mask(row.wprec);
    endtask

    // y_r = sum over k of x_k * W_rk, wrapping at 32 bits
    task automatic compute_expected(input int set, input job_row_t row);
        int y;
        for (int r = 0; r < `MVU_N; r++) begin
            y = 0;
            for (int k = 0; k < `MVU_N; k++)
                y += operand_value(xv[set][k], row.iprec, row.d_signed) *
                     operand_value(wv[set][r][k], row.wprec, row.w_signed);
            expect_y[set][r] = y;
        end
    endtask

    // Splits the operands into bit planes and stores them over the bus
    task automatic load_operands(input int set, input int ibase, input int wbase,
                                 input job_row_t row);
        logic [`MVU_N-1:0]        dword;
        logic [`MVU_N*`MVU_N-1:0] wword;
        for (int b = 0; b < row.iprec; b++) begin
            for (int k = 0; k < `MVU_N; k++)
                dword[k] = xv[set][k][b];
            bus_write(DMEM_BASE + 12'(4 * (ibase + b)), 32'(dword));
        end
        for (int b = 0; b < row.wprec; b++) begin
            for (int r = 0; r < `MVU_N; r++)
                for (int k = 0; k < `MVU_N; k++)
                    wword[r*`MVU_N+k] = wv[set][r][k][b];
            bus_write(WMEM_BASE + 12'(8 * (wbase + b)), wword[31:0]);      // Low half first
            bus_write(WMEM_BASE + 12'(8 * (wbase + b) + 4), wword[63:32]);
        end
    endtask

    task automatic start_job(input job_row_t row, input int ibase, input int wbase);
        bus_write(REG_PREC, {24'h0, row.wprec, row.iprec});
        bus_write(REG_BASE, (32'(wbase) << 8) | 32'(ibase));
        bus_write(REG_CTRL, {29'h0, row.w_signed, row.d_signed, 1'b1});
    endtask

    task automatic wait_done(output logic [31:0] st);
        int n;
        n = 0;
        bus_read(REG_STATUS, st);
        while (!st[1]) begin
            if (n == POLL_TMO)
                stop_on_timeout("done never rose");
            bus_read(REG_STATUS, st);
            n++;
        end
    endtask

    // Waits for done, expects irq with it, then clears irq
    task automatic finish_job();
        logic [31:0] st;
        wait_done(st);
        check_value(32'(st[2]), 32'h1, "irq bit with done");
        bus_write(REG_STATUS, 32'h0);
    endtask

    task automatic check_results(input int set, input string what);
        logic [31:0] rd;
        for (int r = 0; r < `MVU_N; r++) begin
            bus_read(RES_BASE + 12'(4 * r), rd);
            check_value(rd, 32'(expect_y[set][r]), $sformatf("%s row %0d", what, r));
        end
    endtask

    task automatic run_row(input int i);
        make_operands(0, rows[i]);
        compute_expected(0, rows[i]);
        load_operands(0, 0, 0, rows[i]);
        start_job(rows[i], 0, 0);
        finish_job();
        check_results(0, $sformatf("job %0d", i));
    endtask

    task automatic run_group(input int test);
        for (int i = 0; i < n_rows; i++)
            if (rows[i].test == 3'(test))
                run_row(i);
    endtask

    task automatic report_test(input int test, input string name);
        $display("Test %0d %s: %0d errors", test, name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        int n;
        int i;
        wb_req      = '0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        void'($urandom(SEED));
        fill_table();
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n == RST_TMO)
                stop_on_timeout("reset never released");
            @(posedge clk);
            n++;
        end

        bus_read(REG_STATUS, rdata);
        check_value(rdata, 32'h0, "status after reset");
        check_value(32'(irq), 32'h0, "irq pin after reset");
        report_test(1, "reset state");

        run_group(2);
        report_test(2, "unsigned products");

        run_group(3);
        report_test(3, "signed products");

        i = first_row(4);
        make_operands(0, rows[i]);
        compute_expected(0, rows[i]);
        load_operands(0, 0, 0, rows[i]);
        start_job(rows[i], 0, 0);
        wait_done(status);
        check_value(status, 32'h6, "status at done");           // irq, done, idle
        check_value(32'(irq), 32'h1, "irq pin at done");
        bus_write(REG_STATUS, 32'h0);
        bus_read(REG_STATUS, status);
        check_value(status, 32'h2, "status after irq clear");   // done stays
        check_value(32'(irq), 32'h0, "irq pin after clear");
        check_results(0, "completion job");
        report_test(4, "completion signals");

        i = first_row(5);
        make_operands(0, rows[i]);
        compute_expected(0, rows[i]);
        load_operands(0, 0, 0, rows[i]);
        start_job(rows[i], 0, 0);
        bus_read(REG_STATUS, status);
        check_value(status, 32'h1, "busy after start");
        bus_write(REG_CTRL, 32'h7);     // Signed start while busy
        finish_job();
        check_results(0, "job with ignored start");
        make_operands(0, rows[i]);      // Fresh operands, old results would mismatch
        compute_expected(0, rows[i]);
        load_operands(0, 0, 0, rows[i]);
        start_job(rows[i], 0, 0);
        finish_job();
        check_results(0, "later start");
        report_test(5, "start while busy");

        i = first_row(6);
        make_operands(0, rows[i]);
        make_operands(1, rows[i]);
        compute_expected(0, rows[i]);
        compute_expected(1, rows[i]);
        load_operands(0, 0, 0, rows[i]);
        load_operands(1, 8, 16, rows[i]);
        start_job(rows[i], 8, 16);
        finish_job();
        check_results(1, "bases 8/16");
        start_job(rows[i], 0, 0);
        finish_job();
        check_results(0, "bases 0/0");
        report_test(6, "base addresses");

        end_run();
    end

endmodule

//--- hw/mvu_agu.sv
//--------------------------------------------------------------------------
// Bit-plane address generator
// Input bit outer loop, weight bit inner loop, one pair per cycle
// Plane addresses, MSB flags, shift amount, first and last pair
//--------------------------------------------------------------------------
`include "mvu_config.svh"

module mvu_agu (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  mvu_pkg::job_cfg_t  cfg,
    output mvu_pkg::mem_addr_t daddr,
    output mvu_pkg::mem_addr_t waddr,
    output mvu_pkg::agu_ctl_t  ctl
);
    import mvu_pkg::*;

    prec_t ibit;                        // Input bit i
    prec_t wbit;                        // Weight bit j
    logic  ilast;
    logic  wlast;

    assign ilast = (ibit == cfg.iprec - 1'b1);
    assign wlast = (wbit == cfg.wprec - 1'b1);

    // Both counters wrap to 0 on the last pair, ready for the next job
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ibit <= '0;
            wbit <= '0;
        end else if (run) begin
            if (wlast) begin
                wbit <= '0;
                ibit <= ilast ? '0 : ibit + 1'b1;
            end else begin
                wbit <= wbit + 1'b1;
            end
        end
    end

    assign daddr = cfg.ibase + mem_addr_t'(ibit);
    assign waddr = cfg.wbase + mem_addr_t'(wbit);

    assign ctl.valid = run;
    assign ctl.d_msb = ilast;                       // Sign plane of the data
    assign ctl.w_msb = wlast;
    assign ctl.shift = ibit + wbit;
    assign ctl.first = (ibit == '0) && (wbit == '0);
    assign ctl.last  = ilast & wlast;

    // Job planes must fit without wrapping the memory
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        run |-> (int'(cfg.ibase) + int'(ibit) < `MVU_MEM_DEPTH) &&
                (int'(cfg.wbase) + int'(wbit) < `MVU_MEM_DEPTH));

endmodule

//--- hw/mvu_config.svh
//--------------------------------------------------------------------------
// Build-time sizes of the bit-serial MVU
// Vector length, memory depth, accumulator and precision widths
// Memory read latency and VVP pipeline depth
//--------------------------------------------------------------------------
`ifndef MVU_CONFIG_SVH
`define MVU_CONFIG_SVH

// Vector length and matrix size
`define MVU_N           8

// Words per plane memory
`define MVU_MEM_DEPTH   32

`define MVU_BACC        32      // Accumulator width
`define MVU_BPREC       4       // Precision field, legal values 1..8

// Pipeline depths seen by the control delay line
`define MVU_MEM_RD_LAT  1       // Registered read
`define MVU_VVP_STAGES  1       // Popcount register

`endif

//--- hw/mvu_controller.sv
//--------------------------------------------------------------------------
// Job controller of the MVU
// Countdown of iprec*wprec plane pairs, run, busy and done
//--------------------------------------------------------------------------
module mvu_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  mvu_pkg::job_cfg_t cfg,
    input  logic              acc_last,
    output logic              run,
    output logic              busy,
    output logic              done
);
    import mvu_pkg::*;

    localparam int BCNT = 2 * $bits(prec_t);

    logic [BCNT-1:0] count;             // Pairs left to issue

    assign run = (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else if (start && !busy) begin
            count <= BCNT'(cfg.iprec) * BCNT'(cfg.wprec);
            busy  <= 1'b1;
            done  <= 1'b0;              // Held from the previous job until here
        end else begin
            if (run)
                count <= count - 1'b1;
            if (acc_last) begin         // Pipeline drained
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    a_run_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        run |-> busy);

endmodule

//--- hw/mvu_pkg.sv
//--------------------------------------------------------------------------
// Datapath types of the MVU
// Memory address, precision, data and weight planes, accumulator
// Job configuration and AGU control word
//--------------------------------------------------------------------------
`include "mvu_config.svh"

package mvu_pkg;

    typedef logic [$clog2(`MVU_MEM_DEPTH)-1:0] mem_addr_t;
    typedef logic [`MVU_BPREC-1:0]             prec_t;

    typedef logic [`MVU_N-1:0]        dplane_t;    // Bit k is element k
    typedef logic [`MVU_N*`MVU_N-1:0] wplane_t;    // Bit r*N+k is row r, column k

    typedef logic signed [`MVU_BACC-1:0] acc_t;

    // Job latched on start
    typedef struct packed {
        prec_t     iprec;       // Input bits per element
        prec_t     wprec;       // Weight bits per element
        logic      d_signed;    // Data is two's complement
        logic      w_signed;    // Weights are two's complement
        mem_addr_t ibase;       // Plane 0 of the data
        mem_addr_t wbase;       // Plane 0 of the weights
    } job_cfg_t;

    // One plane pair as issued by the AGU
    typedef struct packed {
        logic  valid;
        logic  d_msb;           // Data plane is the sign plane
        logic  w_msb;           // Weight plane is the sign plane
        prec_t shift;           // i+j
        logic  first;           // Load instead of accumulate
        logic  last;            // Final pair of the job
    } agu_ctl_t;

endpackage

//--- hw/mvu_plane_mem.sv
//--------------------------------------------------------------------------
// Bit-plane memory, one write and one read port
// Registered read with one cycle latency, word type set per instance
//--------------------------------------------------------------------------
`include "mvu_config.svh"

module mvu_plane_mem #(
    parameter type word_t = logic [7:0]
) (
    input  logic               clk,
    input  logic               we,
    input  mvu_pkg::mem_addr_t waddr,
    input  word_t              wdata,
    input  mvu_pkg::mem_addr_t raddr,
    output word_t              rdata
);
    word_t mem [`MVU_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];            // Old word on a same-address write
    end

endmodule

//--- hw/mvu_top.sv
//--------------------------------------------------------------------------
// Top level of the bit-serial MVU
// Wishbone slave, controller, AGU, data and weight plane memories
// and the VVP shift-accumulator array
//--------------------------------------------------------------------------
`include "mvu_config.svh"

module mvu_top (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp,
    output logic            irq
);
    import mvu_pkg::*;

    job_cfg_t  cfg;
    logic      start;
    logic      run;
    logic      busy;
    logic      done;
    logic      acc_last;
    logic      dmem_we;
    logic      wmem_we;
    mem_addr_t dmem_waddr;
    mem_addr_t wmem_waddr;
    mem_addr_t daddr;
    mem_addr_t waddr;
    dplane_t   dmem_wdata;
    dplane_t   dplane;
    wplane_t   wmem_wdata;
    wplane_t   wplane;
    agu_ctl_t  ctl;
    acc_t      acc [`MVU_N];

    mvu_wb_regs i_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .busy       (busy),
        .done       (done),
        .acc        (acc),
        .cfg        (cfg),
        .start      (start),
        .irq        (irq),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_waddr),
        .dmem_wdata (dmem_wdata),
        .wmem_we    (wmem_we),
        .wmem_addr  (wmem_waddr),
        .wmem_wdata (wmem_wdata)
    );

    mvu_controller i_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .cfg      (cfg),
        .acc_last (acc_last),
        .run      (run),
        .busy     (busy),
        .done     (done)
    );

    mvu_agu i_agu (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .cfg   (cfg),
        .daddr (daddr),
        .waddr (waddr),
        .ctl   (ctl)
    );

    mvu_plane_mem #(.word_t(dplane_t)) i_dmem (
        .clk   (clk),
        .we    (dmem_we),
        .waddr (dmem_waddr),
        .wdata (dmem_wdata),
        .raddr (daddr),
        .rdata (dplane)
    );

    mvu_plane_mem #(.word_t(wplane_t)) i_wmem (
        .clk   (clk),
        .we    (wmem_we),
        .waddr (wmem_waddr),
        .wdata (wmem_wdata),
        .raddr (waddr),
        .rdata (wplane)
    );

    mvu_vvp_shacc i_vvp (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .ctl_in   (ctl),
        .dplane   (dplane),
        .wplane   (wplane),
        .acc      (acc),
        .acc_last (acc_last)
    );

endmodule

//--- hw/mvu_vvp_shacc.sv
//--------------------------------------------------------------------------
// Vector-vector products and shift-accumulators
// Control delay line matched to memory read and VVP stages
// Per row AND with the data plane, popcount, MSB negation, shift-add
//--------------------------------------------------------------------------
`include "mvu_config.svh"

module mvu_vvp_shacc (
    input  logic              clk,
    input  logic              rst_n,
    input  mvu_pkg::job_cfg_t cfg,
    input  mvu_pkg::agu_ctl_t ctl_in,
    input  mvu_pkg::dplane_t  dplane,
    input  mvu_pkg::wplane_t  wplane,
    output mvu_pkg::acc_t     acc [`MVU_N],
    output logic              acc_last
);
    import mvu_pkg::*;

    localparam int DLY = `MVU_MEM_RD_LAT + `MVU_VVP_STAGES;
    localparam int BPC = $clog2(`MVU_N + 1);

    agu_ctl_t       ctl_dly [DLY];
    agu_ctl_t       ctl_acc;                        // Control at the accumulators
    logic [BPC-1:0] pc_row  [`MVU_N];
    logic [BPC-1:0] pc_pipe [`MVU_VVP_STAGES][`MVU_N];
    acc_t           term    [`MVU_N];
    logic           neg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < DLY; s++)
                ctl_dly[s] <= '0;
        end else begin
            ctl_dly[0] <= ctl_in;
            for (int s = 1; s < DLY; s++)
                ctl_dly[s] <= ctl_dly[s-1];
        end
    end

    // Row r of the weight plane against the data plane
    always_comb begin
        for (int r = 0; r < `MVU_N; r++) begin
            pc_row[r] = '0;
            for (int k = 0; k < `MVU_N; k++)
                pc_row[r] = pc_row[r] + BPC'(wplane[r*`MVU_N+k] & dplane[k]);
        end
    end

    always_ff @(posedge clk) begin
        pc_pipe[0] <= pc_row;
        for (int s = 1; s < `MVU_VVP_STAGES; s++)
            pc_pipe[s] <= pc_pipe[s-1];
    end

    assign ctl_acc  = ctl_dly[DLY-1];
    assign acc_last = ctl_acc.valid & ctl_acc.last;
    assign neg      = (cfg.d_signed & ctl_acc.d_msb) ^ (cfg.w_signed & ctl_acc.w_msb);

    always_comb begin
        for (int r = 0; r < `MVU_N; r++) begin
            term[r] = acc_t'(pc_pipe[`MVU_VVP_STAGES-1][r]);
            if (neg)
                term[r] = -term[r];                 // Sign plane weighs -2^(p-1)
            term[r] = term[r] <<< ctl_acc.shift;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_acc.valid) begin
            for (int r = 0; r < `MVU_N; r++)
                acc[r] <= ctl_acc.first ? term[r] : acc[r] + term[r];
        end
    end

    a_shift_max: assert property (@(posedge clk) disable iff (!rst_n)
        ctl_in.valid |-> ctl_in.shift <= 4'd14);

endmodule

//--- hw/mvu_wb_regs.sv
//--------------------------------------------------------------------------
// Wishbone slave of the MVU
// Address decode, staged configuration and job buffer, start pulse
// Plane memory write ports, sticky irq, status and result readback
//--------------------------------------------------------------------------
`include "mvu_config.svh"

module mvu_wb_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_pkg::wb_req_t    wb_req,
    output wb_pkg::wb_rsp_t    wb_rsp,
    input  logic               busy,
    input  logic               done,
    input  mvu_pkg::acc_t      acc [`MVU_N],
    output mvu_pkg::job_cfg_t  cfg,
    output logic               start,
    output logic               irq,
    output logic               dmem_we,
    output mvu_pkg::mem_addr_t dmem_addr,
    output mvu_pkg::dplane_t   dmem_wdata,
    output logic               wmem_we,
    output mvu_pkg::mem_addr_t wmem_addr,
    output mvu_pkg::wplane_t   wmem_wdata
);
    import mvu_pkg::*;
    import wb_pkg::*;

    localparam int BRES  = $clog2(`MVU_N);
    localparam int WHALF = `MVU_N * `MVU_N / 2;

    logic             access;       // New cycle, not yet acknowledged
    logic             wr;
    logic [3:0]       page;
    logic             go;           // Accepted start
    logic             done_q;
    logic             done_rise;
    logic             irq_q;
    logic             ack_q;
    logic [31:0]      dat_q;
    logic [31:0]      rd_data;
    logic [WHALF-1:0] wlo_q;        // Low half of the next weight plane
    job_cfg_t         stage_q;
    job_cfg_t         stage_d;

    assign access = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr     = access & wb_req.we;
    assign page   = wb_req.adr[11:8];
    assign go     = wr && wb_req.adr == REG_CTRL && wb_req.dat_w[0] && !busy && !start;

    assign dmem_we    = wr && page == DMEM_BASE[11:8];
    assign dmem_addr  = wb_req.adr[6:2];
    assign dmem_wdata = wb_req.dat_w[`MVU_N-1:0];
    assign wmem_we    = wr && page == WMEM_BASE[11:8] && wb_req.adr[2];  // High half commits
    assign wmem_addr  = wb_req.adr[7:3];
    assign wmem_wdata = {wb_req.dat_w[WHALF-1:0], wlo_q};

    assign done_rise = done & ~done_q;
    assign irq       = irq_q | done_rise;       // Set together with done
    assign wb_rsp    = '{ack: ack_q, dat_r: dat_q};

    always_comb begin
        stage_d = stage_q;
        if (wr && wb_req.adr == REG_CTRL) begin
            stage_d.d_signed = wb_req.dat_w[1];
            stage_d.w_signed = wb_req.dat_w[2];
        end
        if (wr && wb_req.adr == REG_PREC) begin
            stage_d.iprec = wb_req.dat_w[3:0];
            stage_d.wprec = wb_req.dat_w[7:4];
        end
        if (wr && wb_req.adr == REG_BASE) begin
            stage_d.ibase = wb_req.dat_w[4:0];
            stage_d.wbase = wb_req.dat_w[12:8];
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            REG_CTRL:   rd_data = 32'({cfg.w_signed, cfg.d_signed, 1'b0});
            REG_PREC:   rd_data = 32'({stage_q.wprec, stage_q.iprec});
            REG_BASE:   rd_data = 32'({stage_q.wbase, 3'b000, stage_q.ibase});
            REG_STATUS: rd_data = 32'({irq, done, busy});
            default: begin
                if (page == RES_BASE[11:8])
                    rd_data = acc[wb_req.adr[BRES+1:2]];    // One word per row
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            start   <= 1'b0;
            done_q  <= 1'b0;
            irq_q   <= 1'b0;
            stage_q <= '0;
            cfg     <= '0;
        end else begin
            ack_q   <= access;              // No wait states
            start   <= go;
            done_q  <= done;
            stage_q <= stage_d;
            if (go)
                cfg <= stage_d;             // Job buffer, stable while busy
            if (done_rise)
                irq_q <= 1'b1;
            else if (wr && wb_req.adr == REG_STATUS)
                irq_q <= 1'b0;              // Any write clears
        end
    end

    always_ff @(posedge clk) begin
        dat_q <= rd_data;
        if (wr && page == WMEM_BASE[11:8] && !wb_req.adr[2])
            wlo_q <= wb_req.dat_w[WHALF-1:0];
    end

    a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack_q) |-> $past(wb_req.cyc && wb_req.stb));

endmodule

//--- hw/wb_pkg.sv
//--------------------------------------------------------------------------
// Wishbone classic slave types and the MVU address map
// Request and response structs, byte addresses of registers and windows
//--------------------------------------------------------------------------
package wb_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [11:0] adr;       // Byte address
        logic [31:0] dat_w;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;       // One cycle, registered
        logic [31:0] dat_r;     // Valid with ack
    } wb_rsp_t;

    // Registers
    localparam logic [11:0] REG_CTRL   = 12'h000;  // Start, d_signed, w_signed
    localparam logic [11:0] REG_PREC   = 12'h004;  // iprec 3:0, wprec 7:4
    localparam logic [11:0] REG_BASE   = 12'h008;  // ibase 4:0, wbase 12:8
    localparam logic [11:0] REG_STATUS = 12'h00C;  // busy, done, irq

    // Windows, selected by adr[11:8]
    localparam logic [11:0] DMEM_BASE  = 12'h100;  // 4 bytes per data plane
    localparam logic [11:0] WMEM_BASE  = 12'h200;  // 8 bytes per weight plane
    localparam logic [11:0] RES_BASE   = 12'h300;  // Accumulators, read only

endpackage

//--- mvu_top.f
+incdir+hw
hw/mvu_pkg.sv
hw/wb_pkg.sv
hw/mvu_plane_mem.sv
hw/mvu_agu.sv
hw/mvu_controller.sv
hw/mvu_vvp_shacc.sv
hw/mvu_wb_regs.sv
hw/mvu_top.sv
bench/mvu_tb_clock.sv
bench/mvu_top_tb.sv
